// File: source/io_scan_pkg.sv
`default_nettype none

package io_scan_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int BYTE_W    = 8;  // Parallel bus data.
    localparam int REG_NUM_W = 4;  // Enough for 16 boards.
    localparam int ADDR_W    = 4;

    // ------------------------------
    // Sequencer states
    // ------------------------------
    // One pass through the three states per channel.
    typedef enum logic [1:0] {
        SCAN_IDLE   = 2'd0,  // Step to the next channel.
        SCAN_ADDR   = 2'd1,  // Address settles on the bus.
        SCAN_STROBE = 2'd2   // Bank enable active.
    } scan_state_e;

    // ------------------------------
    // Host opcodes
    // ------------------------------
    typedef enum logic [0:0] {
        OP_WRITE_OUT = 1'b0,  // Load an output byte.
        OP_READ_IN   = 1'b1   // Fetch a captured input byte.
    } host_op_e;

endpackage

`default_nettype wire

// File: source/io_scan_sequencer.sv
`default_nettype none

module io_scan_sequencer #(
    parameter int INSTALLED_BOARDS = 2
) (
    input  wire                               Clk,
    input  wire                               Rst_n,
    output logic [io_scan_pkg::ADDR_W-1:0]    bus_addr,
    output logic [1:0]                        bus_enable_n,
    output logic [io_scan_pkg::REG_NUM_W-1:0] scan_reg,
    output logic                              scan_write,
    output logic                              scan_strobe
);

    import io_scan_pkg::*;

    // Channel is the board number with the direction bit below it.
    localparam int CH_W = REG_NUM_W + 1;
    localparam logic [CH_W-1:0] LAST_CH = CH_W'(2 * INSTALLED_BOARDS - 1);

    scan_state_e     state;
    scan_state_e     next_state;
    logic [CH_W-1:0] channel;
    logic            upper_bank;

    // ------------------------------
    // State machine
    // ------------------------------
    always_comb begin
        case (state)
            SCAN_IDLE: next_state = SCAN_ADDR;
            SCAN_ADDR: next_state = SCAN_STROBE;
            default:   next_state = SCAN_IDLE;
        endcase
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state   <= SCAN_IDLE;
            channel <= '0;
        end else begin
            state <= next_state;
            if (state == SCAN_IDLE) begin
                channel <= (channel == LAST_CH) ? '0 : channel + 1'b1;
            end
        end
    end

    // ------------------------------
    // Bus control
    // ------------------------------
    assign scan_strobe = (state == SCAN_STROBE);
    assign scan_write  = channel[0];  // Odd channels are outputs.
    assign scan_reg    = channel[CH_W-1:1];
    assign upper_bank  = channel[CH_W-1];

    // Direction bit rotated to the top of the address.
    assign bus_addr = {channel[0], channel[ADDR_W-1:1]};

    assign bus_enable_n[0] = ~(scan_strobe & ~upper_bank);
    assign bus_enable_n[1] = ~(scan_strobe & upper_bank);

    a_bank_exclusive: assert property (@(posedge Clk) disable iff (!Rst_n)
        bus_enable_n != 2'b00)
        else $error("Both bank enables low at the same time.");

    a_channel_range: assert property (@(posedge Clk) disable iff (!Rst_n)
        channel <= LAST_CH)
        else $error("Channel %0d beyond the installed boards.", channel);

endmodule

`default_nettype wire

// File: source/io_input_capture.sv
`default_nettype none

module io_input_capture #(
    parameter int BOARDS = 16
) (
    input  wire                                   Clk,
    input  wire                                   Rst_n,
    input  wire                                   scan_strobe,
    input  wire                                   scan_write,
    input  wire  [io_scan_pkg::REG_NUM_W-1:0]     scan_reg,
    input  wire  [io_scan_pkg::BYTE_W-1:0]        bus_data_in,
    output logic [BOARDS*io_scan_pkg::BYTE_W-1:0] in_image
);

    import io_scan_pkg::*;

    logic [BYTE_W-1:0] image_q [BOARDS];
    logic              capture;

    // Board returns its byte while an input channel is strobed.
    assign capture = scan_strobe & ~scan_write;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            for (int i = 0; i < BOARDS; i++) begin
                image_q[i] <= '0;
            end
        end else if (capture && (int'(scan_reg) < BOARDS)) begin
            image_q[scan_reg] <= bus_data_in;  // Held until the next scan.
        end
    end

    // Flatten for the host side.
    always_comb begin
        for (int i = 0; i < BOARDS; i++) begin
            in_image[i*BYTE_W +: BYTE_W] = image_q[i];
        end
    end

endmodule

`default_nettype wire

// File: source/io_host_regs.sv
`default_nettype none

module io_host_regs #(
    parameter int BOARDS    = 16,
    parameter int CMD_DEPTH = 4
) (
    input  wire                                   Clk,
    input  wire                                   Rst_n,
    input  wire                                   cmd_valid,
    input  wire  io_scan_pkg::host_op_e           cmd_op,
    input  wire  [io_scan_pkg::REG_NUM_W-1:0]     cmd_reg,
    input  wire  [io_scan_pkg::BYTE_W-1:0]        cmd_data,
    input  wire  [io_scan_pkg::REG_NUM_W-1:0]     scan_reg,
    input  wire  [BOARDS*io_scan_pkg::BYTE_W-1:0] in_image,
    output logic                                  cmd_credit,
    output logic                                  rsp_valid,
    output logic [io_scan_pkg::REG_NUM_W-1:0]     rsp_reg,
    output logic [io_scan_pkg::BYTE_W-1:0]        rsp_data,
    output logic [io_scan_pkg::BYTE_W-1:0]        out_byte
);

    import io_scan_pkg::*;

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(CMD_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(CMD_DEPTH);

    host_op_e             op_q   [CMD_DEPTH];
    logic [REG_NUM_W-1:0] reg_q  [CMD_DEPTH];
    logic [BYTE_W-1:0]    data_q [CMD_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 push;
    logic                 pop;
    logic                 retire_read;
    logic                 retire_write;
    logic [BYTE_W-1:0]    head_in;
    logic [BYTE_W-1:0]    out_regs [BOARDS];

    // ------------------------------
    // Command queue
    // ------------------------------
    assign push = cmd_valid && (count != FULL_CNT);
    assign pop  = (count != '0);  // One retirement per cycle.

    always_ff @(posedge Clk) begin
        if (push) begin
            op_q[wr_ptr]   <= cmd_op;
            reg_q[wr_ptr]  <= cmd_reg;
            data_q[wr_ptr] <= cmd_data;
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------
    // Retirement
    // ------------------------------
    assign retire_read  = pop && (op_q[rd_ptr] == OP_READ_IN);
    assign retire_write = pop && (op_q[rd_ptr] == OP_WRITE_OUT);
    assign head_in = (int'(reg_q[rd_ptr]) < BOARDS) ?
                     in_image[reg_q[rd_ptr]*BYTE_W +: BYTE_W] : '0;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            cmd_credit <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            cmd_credit <= pop;          // Credit back per retired command.
            rsp_valid  <= retire_read;
        end
    end

    always_ff @(posedge Clk) begin
        if (retire_read) begin
            rsp_reg  <= reg_q[rd_ptr];
            rsp_data <= head_in;
        end
    end

    // ------------------------------
    // Output register file
    // ------------------------------
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            for (int i = 0; i < BOARDS; i++) begin
                out_regs[i] <= '0;
            end
        end else if (retire_write && (int'(reg_q[rd_ptr]) < BOARDS)) begin
            out_regs[reg_q[rd_ptr]] <= data_q[rd_ptr];
        end
    end

    assign out_byte = (int'(scan_reg) < BOARDS) ? out_regs[scan_reg] : '0;

    // Host may only send while it still holds a credit.
    a_credit_overrun: assert property (@(posedge Clk) disable iff (!Rst_n)
        cmd_valid |-> (count != FULL_CNT))
        else $error("Command arrived with the queue full.");

endmodule

`default_nettype wire

// File: source/io_scan_top.sv
`default_nettype none

module io_scan_top #(
    parameter int BOARDS           = 16,
    parameter int INSTALLED_BOARDS = 2,
    parameter int CMD_DEPTH        = 4
) (
    input  wire                               Clk,
    input  wire                               Rst_n,
    input  wire                               cmd_valid,
    input  wire io_scan_pkg::host_op_e        cmd_op,
    input  wire [io_scan_pkg::REG_NUM_W-1:0]  cmd_reg,
    input  wire [io_scan_pkg::BYTE_W-1:0]     cmd_data,
    input  wire [io_scan_pkg::BYTE_W-1:0]     bus_data_in,
    output wire                               cmd_credit,
    output wire                               rsp_valid,
    output wire [io_scan_pkg::REG_NUM_W-1:0]  rsp_reg,
    output wire [io_scan_pkg::BYTE_W-1:0]     rsp_data,
    output wire [io_scan_pkg::ADDR_W-1:0]     bus_addr,
    output wire [1:0]                         bus_enable_n,
    output wire [io_scan_pkg::BYTE_W-1:0]     bus_data_out,
    output wire                               bus_data_oe
);

    import io_scan_pkg::*;

    wire [REG_NUM_W-1:0]     scan_reg;
    wire                     scan_write;
    wire                     scan_strobe;
    wire [BOARDS*BYTE_W-1:0] in_image;

    assign bus_data_oe = scan_write;  // Drive only on output channels.

    io_scan_sequencer #(
        .INSTALLED_BOARDS(INSTALLED_BOARDS)
    ) u_sequencer (
        .Clk         (Clk),
        .Rst_n       (Rst_n),
        .bus_addr    (bus_addr),
        .bus_enable_n(bus_enable_n),
        .scan_reg    (scan_reg),
        .scan_write  (scan_write),
        .scan_strobe (scan_strobe)
    );

    io_input_capture #(
        .BOARDS(BOARDS)
    ) u_input_capture (
        .Clk        (Clk),
        .Rst_n      (Rst_n),
        .scan_strobe(scan_strobe),
        .scan_write (scan_write),
        .scan_reg   (scan_reg),
        .bus_data_in(bus_data_in),
        .in_image   (in_image)
    );

    io_host_regs #(
        .BOARDS   (BOARDS),
        .CMD_DEPTH(CMD_DEPTH)
    ) u_host_regs (
        .Clk       (Clk),
        .Rst_n     (Rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_reg   (cmd_reg),
        .cmd_data  (cmd_data),
        .scan_reg  (scan_reg),
        .in_image  (in_image),
        .cmd_credit(cmd_credit),
        .rsp_valid (rsp_valid),
        .rsp_reg   (rsp_reg),
        .rsp_data  (rsp_data),
        .out_byte  (bus_data_out)
    );

endmodule

`default_nettype wire

// File: dv/io_clock_gen.sv
`default_nettype none

module io_clock_gen (
    output logic Clk,
    output logic Rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;  // 20 ns period.
    end

    initial begin
        Rst_n = 1'b0;
        repeat (3) @(posedge Clk);
        #2 Rst_n = 1'b1;  // Released clear of the edge.
    end

endmodule

`default_nettype wire

// File: dv/io_board_model.sv
`default_nettype none

module io_board_model #(
    parameter int BOARDS = 16
) (
    input  wire                                   Clk,
    input  wire                                   Rst_n,
    input  wire  [io_scan_pkg::ADDR_W-1:0]        bus_addr,
    input  wire  [1:0]                            bus_enable_n,
    input  wire  [io_scan_pkg::BYTE_W-1:0]        bus_data_out,
    input  wire                                   bus_data_oe,
    output logic [io_scan_pkg::BYTE_W-1:0]        bus_data_in,
    output logic [BOARDS*io_scan_pkg::BYTE_W-1:0] last_in
);

    timeunit 1ns;
    timeprecision 100ps;

    import io_scan_pkg::*;

    logic [31:0]          rng;
    logic [BYTE_W-1:0]    present [BOARDS];  // Byte each board returns next.
    logic [BYTE_W-1:0]    latched [BOARDS];  // Byte each board took from the bus.
    int                   out_count [BOARDS];
    logic [REG_NUM_W-1:0] board;
    logic                 strobe;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Direction bit sits on top of the address.
    assign board       = {bus_enable_n[0], bus_addr[ADDR_W-2:0]};  // Upper bank is boards 8 up.
    assign strobe      = (bus_enable_n != 2'b11);
    assign bus_data_in = present[board];

    initial begin
        rng     = 32'hea08;
        last_in <= '0;
        for (int i = 0; i < BOARDS; i++) begin
            rng          = xorshift32(rng);
            present[i]   <= rng[BYTE_W-1:0];
            latched[i]   <= '0;
            out_count[i] <= 0;
        end
    end

    always @(posedge Clk) begin
        if (Rst_n && strobe) begin
            if (bus_data_oe) begin
                latched[board]   <= bus_data_out;
                out_count[board] <= out_count[board] + 1;
            end else begin
                last_in[int'(board)*BYTE_W +: BYTE_W] <= present[board];
                rng = xorshift32(rng);
                present[board] <= rng[BYTE_W-1:0];  // New byte for the next scan.
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/io_scan_checker.sv
`default_nettype none

module io_scan_checker #(
    parameter int BOARDS           = 16,
    parameter int INSTALLED_BOARDS = 2
) (
    input wire                                   Clk,
    input wire                                   Rst_n,
    input wire [io_scan_pkg::ADDR_W-1:0]         bus_addr,
    input wire [1:0]                             bus_enable_n,
    input wire                                   bus_data_oe,
    input wire                                   cmd_credit,
    input wire                                   rsp_valid,
    input wire [io_scan_pkg::REG_NUM_W-1:0]      rsp_reg,
    input wire [io_scan_pkg::BYTE_W-1:0]         rsp_data,
    input wire [BOARDS*io_scan_pkg::BYTE_W-1:0]  model_in
);

    timeunit 1ns;
    timeprecision 100ps;

    import io_scan_pkg::*;

    localparam int CH_W = REG_NUM_W + 1;
    localparam logic [CH_W-1:0] LAST_CH = CH_W'(2 * INSTALLED_BOARDS - 1);

    int                      errors = 0;
    int                      tests_ok = 0;
    int                      tests_bad = 0;
    int                      mark = 0;
    int                      strobes = 0;
    int                      credits_seen = 0;
    int                      rsp_seen = 0;
    int                      cyc = 0;
    bit                      seen_first = 0;
    bit                      after_reset = 0;
    logic [CH_W-1:0]         exp_ch = '0;
    logic [REG_NUM_W-1:0]    exp_regs [$];
    logic [REG_NUM_W-1:0]    want_reg;
    logic [BYTE_W-1:0]       rsp_data_q;
    logic [BYTE_W-1:0]       rsp_exp_q;
    logic [BOARDS*BYTE_W-1:0] prev_snap = '0;

    task automatic fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic begin_test();
        mark = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            tests_ok++;
            $display("%0t ns  test %-16s ok", $time, name);
        end else begin
            tests_bad++;
            $display("%0t ns  test %-16s FAILED", $time, name);
        end
    endtask

    task automatic compare_byte(input string what, input logic [BYTE_W-1:0] got,
                                input logic [BYTE_W-1:0] exp);
        if (got !== exp) begin
            fail($sformatf("%s: got %02h, expected %02h", what, got, exp));
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp);
        if (got != exp) begin
            fail($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic expect_rsp(input logic [REG_NUM_W-1:0] r);
        exp_regs.push_back(r);
    endtask

    task automatic report_counts();
        $display("Tests: %0d passed, %0d failed, %0d check errors, %0d strobes",
                 tests_ok, tests_bad, errors, strobes);
    endtask

    // ------------------------------
    // Bus and host port monitor
    // ------------------------------
    always @(negedge Clk) begin
        if (!Rst_n || after_reset) begin
            if (bus_enable_n !== 2'b11 || bus_data_oe !== 1'b0 ||
                cmd_credit !== 1'b0 || rsp_valid !== 1'b0) begin
                fail("Outputs not idle around reset.");
            end
        end
        after_reset = !Rst_n;
        if (!Rst_n) begin
            exp_ch     = '0;
            cyc        = 0;
            seen_first = 0;
        end else begin
            cyc++;
            if (bus_enable_n == 2'b00) begin
                fail("Both bank enables low.");
            end else if (bus_enable_n != 2'b11) begin
                exp_ch = (exp_ch == LAST_CH) ? '0 : exp_ch + 1'b1;
                compare_byte("Strobe address", 8'(bus_addr),
                             8'({exp_ch[0], exp_ch[ADDR_W-1:1]}));
                compare_byte("Bank enable", 8'(bus_enable_n),
                             exp_ch[CH_W-1] ? 8'h01 : 8'h02);
                compare_byte("Drive enable", 8'(bus_data_oe), 8'(exp_ch[0]));
                if (seen_first && cyc != 3) begin
                    fail($sformatf("Strobe spacing %0d cycles, expected 3", cyc));
                end
                seen_first = 1;
                cyc        = 0;
                strobes++;
            end
            if (cmd_credit) begin
                credits_seen++;
            end
            if (rsp_valid) begin
                if (exp_regs.size() == 0) begin
                    fail("Response arrived with no command waiting for one.");
                end else begin
                    want_reg = exp_regs.pop_front();
                    compare_byte("Response register", 8'(rsp_reg), 8'(want_reg));
                end
                rsp_data_q = rsp_data;
                rsp_exp_q  = prev_snap[int'(rsp_reg)*BYTE_W +: BYTE_W];
                rsp_seen++;
            end
        end
        prev_snap = model_in;  // Image as it stands before the next edge.
    end

endmodule

`default_nettype wire

// File: dv/io_scan_tb.sv
`default_nettype none

module io_scan_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import io_scan_pkg::*;

    localparam int BOARDS           = 16;
    localparam int INSTALLED_BOARDS = 2;
    localparam int CMD_DEPTH        = 4;
    localparam int ROUND            = 6 * INSTALLED_BOARDS;
    localparam int NUM_TESTS        = 6;
    localparam int TIMEOUT_NS       = (NUM_TESTS + 4) * ROUND * 20 + 2000;

    // ------------------------------
    // Stimulus table
    // ------------------------------
    host_op_e             t_op    [NUM_TESTS] = '{OP_WRITE_OUT, OP_WRITE_OUT, OP_READ_IN,
                                                  OP_READ_IN, OP_READ_IN, OP_WRITE_OUT};
    logic [REG_NUM_W-1:0] t_reg   [NUM_TESTS] = '{4'd0, 4'd1, 4'd0, 4'd1, 4'd5, 4'd0};
    logic [BYTE_W-1:0]    t_data  [NUM_TESTS] = '{8'ha5, 8'h3c, 8'h00, 8'h00, 8'h00, 8'h0f};
    logic [BYTE_W-1:0]    t_exp   [NUM_TESTS] = '{8'ha5, 8'h3c, 8'h00, 8'h00, 8'h00, 8'h0f};
    bit                   t_model [NUM_TESTS] = '{0, 0, 1, 1, 0, 0};  // Expect the model byte.

    logic [REG_NUM_W-1:0] burst_reg [CMD_DEPTH] = '{4'd0, 4'd1, 4'd5, 4'd1};

    wire                    Clk;
    wire                    Rst_n;
    logic                   cmd_valid;
    host_op_e               cmd_op;
    logic [REG_NUM_W-1:0]   cmd_reg;
    logic [BYTE_W-1:0]      cmd_data;
    wire  [BYTE_W-1:0]      bus_data_in;
    wire                    cmd_credit;
    wire                    rsp_valid;
    wire  [REG_NUM_W-1:0]   rsp_reg;
    wire  [BYTE_W-1:0]      rsp_data;
    wire  [ADDR_W-1:0]      bus_addr;
    wire  [1:0]             bus_enable_n;
    wire  [BYTE_W-1:0]      bus_data_out;
    wire                    bus_data_oe;
    wire  [BOARDS*BYTE_W-1:0] model_in;
    int                     credits = CMD_DEPTH;
    int                     issued = 0;

    io_clock_gen u_clock_gen (.Clk(Clk), .Rst_n(Rst_n));

    io_scan_top #(
        .BOARDS          (BOARDS),
        .INSTALLED_BOARDS(INSTALLED_BOARDS),
        .CMD_DEPTH       (CMD_DEPTH)
    ) u_io_scan_top (
        .Clk(Clk), .Rst_n(Rst_n), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_reg(cmd_reg), .cmd_data(cmd_data), .bus_data_in(bus_data_in),
        .cmd_credit(cmd_credit), .rsp_valid(rsp_valid), .rsp_reg(rsp_reg),
        .rsp_data(rsp_data), .bus_addr(bus_addr), .bus_enable_n(bus_enable_n),
        .bus_data_out(bus_data_out), .bus_data_oe(bus_data_oe)
    );

    io_board_model #(.BOARDS(BOARDS)) u_model (
        .Clk(Clk), .Rst_n(Rst_n), .bus_addr(bus_addr), .bus_enable_n(bus_enable_n),
        .bus_data_out(bus_data_out), .bus_data_oe(bus_data_oe),
        .bus_data_in(bus_data_in), .last_in(model_in)
    );

    io_scan_checker #(.BOARDS(BOARDS), .INSTALLED_BOARDS(INSTALLED_BOARDS)) u_checker (
        .Clk(Clk), .Rst_n(Rst_n), .bus_addr(bus_addr), .bus_enable_n(bus_enable_n),
        .bus_data_oe(bus_data_oe), .cmd_credit(cmd_credit), .rsp_valid(rsp_valid),
        .rsp_reg(rsp_reg), .rsp_data(rsp_data), .model_in(model_in)
    );

    // One clock, then inputs move 2 ns after the edge.
    task automatic step();
        @(posedge Clk);
        #2;
        if (cmd_credit) credits++;
        cmd_valid = 1'b0;
    endtask

    task automatic issue(input host_op_e op, input logic [REG_NUM_W-1:0] r,
                         input logic [BYTE_W-1:0] d);
        while (credits == 0) step();
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_reg   = r;
        cmd_data  = d;
        credits--;
        issued++;
    endtask

    task automatic run_entry(input int i);
        int                n;
        int                cnt;
        logic [BYTE_W-1:0] exp;
        if (t_op[i] == OP_WRITE_OUT) begin
            issue(t_op[i], t_reg[i], t_data[i]);
            step();
            while (credits != CMD_DEPTH) step();
            cnt = u_model.out_count[t_reg[i]];
            while (u_model.out_count[t_reg[i]] == cnt) step();  // Next output strobe.
            u_checker.compare_byte("Board latched byte", u_model.latched[t_reg[i]], t_exp[i]);
        end else begin
            repeat (ROUND + 2) step();
            n = u_checker.rsp_seen;
            u_checker.expect_rsp(t_reg[i]);
            issue(t_op[i], t_reg[i], t_data[i]);
            step();
            while (u_checker.rsp_seen == n) step();
            exp = t_model[i] ? u_checker.rsp_exp_q : t_exp[i];
            u_checker.compare_byte("Read data", u_checker.rsp_data_q, exp);
        end
    endtask

    initial begin
        int n;
        int c;
        cmd_valid = 1'b0;
        cmd_op    = OP_WRITE_OUT;
        cmd_reg   = '0;
        cmd_data  = '0;
        u_checker.begin_test();
        wait (Rst_n === 1'b1);
        step();
        u_checker.end_test("reset state");

        for (int i = 0; i < NUM_TESTS; i++) begin
            u_checker.begin_test();
            run_entry(i);
            u_checker.end_test($sformatf("entry %0d", i));
        end

        // ------------------------------
        // Back to back commands
        // ------------------------------
        u_checker.begin_test();
        while (credits != CMD_DEPTH) step();
        n = u_checker.rsp_seen;
        c = u_checker.credits_seen;
        for (int k = 0; k < CMD_DEPTH; k++) begin
            u_checker.expect_rsp(burst_reg[k]);
            issue(OP_READ_IN, burst_reg[k], 8'h00);
            step();
        end
        while (u_checker.rsp_seen - n < CMD_DEPTH) step();
        u_checker.compare_count("Credit pulses", u_checker.credits_seen - c, CMD_DEPTH);
        u_checker.end_test("credit burst");

        u_checker.begin_test();
        u_checker.compare_count("Total credit pulses", u_checker.credits_seen, issued);
        if (u_checker.strobes < ROUND) u_checker.fail("Too few strobes seen.");
        u_checker.end_test("scan order");

        u_checker.report_counts();
        if (u_checker.errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished.");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/io_scan_pkg.sv
source/io_scan_sequencer.sv
source/io_input_capture.sv
source/io_host_regs.sv
source/io_scan_top.sv
dv/io_clock_gen.sv
dv/io_board_model.sv
dv/io_scan_checker.sv
dv/io_scan_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scan controller testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module io_scan_tb \
    -f sources.f \
    -o sim_io_scan

out=$(./obj_dir/sim_io_scan)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
